//--- files.f
verilog/hdc_hv_pkg.sv
verilog/hdc_reg_pkg.sv
verilog/item_generator.sv
verilog/item_memory.sv
verilog/axi_lite_regs.sv
verilog/hdc_item_top.sv
tb/tb_hdc_item_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hdc_item_top -f files.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/tb_hdc_item_top.sv
`timescale 1ns/1ns

module tb_hdc_item_top;

    // handshake wait limit in cycles
    localparam int WAIT_MAX = 50;
    // ctrl polls before generation counts as stuck
    localparam int POLL_MAX = 200;

    logic                               AXIS_ACLK;
    logic                               S_AXI_ARESETN;
    logic [hdc_reg_pkg::AXI_ADDR_W-1:0] s_axi_awaddr;
    logic                               s_axi_awvalid;
    logic                               s_axi_awready;
    logic [hdc_hv_pkg::WORD_W-1:0]      s_axi_wdata;
    logic                               s_axi_wvalid;
    logic                               s_axi_wready;
    logic [1:0]                         s_axi_bresp;
    logic                               s_axi_bvalid;
    logic                               s_axi_bready;
    logic [hdc_reg_pkg::AXI_ADDR_W-1:0] s_axi_araddr;
    logic                               s_axi_arvalid;
    logic                               s_axi_arready;
    logic [hdc_hv_pkg::WORD_W-1:0]      s_axi_rdata;
    logic [1:0]                         s_axi_rresp;
    logic                               s_axi_rvalid;
    logic                               s_axi_rready;

    // stimulus stream state
    logic [31:0] rand_state;

    hdc_item_top hdc_item_top_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    // 8 ns period
    initial begin
        AXIS_ACLK = 1'b0;
        forever #4 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ----------------------------------------
    // random numbers and reporting
    // ----------------------------------------

    // one xorshift step with shifts 13 17 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rand_state = xorshift32(rand_state);
        return rand_state;
    endfunction

    // 0 for both together and 1 or 2 for address or data first
    function automatic int pick_order();
        return int'(rand_word() % 32'd3);
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        abort_run();
    endtask

    // ----------------------------------------
    // address builders
    // ----------------------------------------
    function automatic logic [31:0] reg_addr(input logic [1:0] win, input logic [7:0] idx);
        hdc_reg_pkg::axi_loc_u loc;
        loc = '0;
        loc.regs.win = win;
        loc.regs.idx = idx;
        return 32'(loc);
    endfunction

    function automatic logic [31:0] item_addr(input logic [3:0] item, input logic [1:0] word);
        hdc_reg_pkg::axi_loc_u loc;
        loc = '0;
        loc.mem.win = hdc_reg_pkg::WIN_ITEM;
        loc.mem.item = item;
        loc.mem.word = word;
        return 32'(loc);
    endfunction

    // ----------------------------------------
    // bus tasks
    // ----------------------------------------

    // handshakes sampled at negedge and drive changes at posedge
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input int order);
        logic aw_started;
        logic w_started;
        logic aw_done;
        logic w_done;
        logic aw_hit;
        logic w_hit;
        int   cnt;
        int   delay;
        aw_started = (order != 2);
        w_started = (order != 1);
        aw_done = 1'b0;
        w_done = 1'b0;
        cnt = 0;
        @(posedge AXIS_ACLK);
        s_axi_awaddr <= addr;
        s_axi_wdata <= data;
        s_axi_awvalid <= aw_started;
        s_axi_wvalid <= w_started;
        while (!(aw_done && w_done)) begin
            @(negedge AXIS_ACLK);
            aw_hit = s_axi_awvalid && s_axi_awready;
            w_hit = s_axi_wvalid && s_axi_wready;
            @(posedge AXIS_ACLK);
            if (aw_hit) begin
                s_axi_awvalid <= 1'b0;
                aw_done = 1'b1;
            end
            if (w_hit) begin
                s_axi_wvalid <= 1'b0;
                w_done = 1'b1;
            end
            // second channel opens once the first one is through
            if (aw_done && !w_started) begin
                s_axi_wvalid <= 1'b1;
                w_started = 1'b1;
            end
            if (w_done && !aw_started) begin
                s_axi_awvalid <= 1'b1;
                aw_started = 1'b1;
            end
            cnt++;
            if (cnt > WAIT_MAX) report_timeout("awready and wready");
        end
        cnt = 0;
        @(negedge AXIS_ACLK);
        while (!s_axi_bvalid) begin
            cnt++;
            if (cnt > WAIT_MAX) report_timeout("bvalid");
            @(negedge AXIS_ACLK);
        end
        check_value("s_axi_bresp", 32'(hdc_reg_pkg::RESP_OKAY), 32'(s_axi_bresp));
        // bvalid must hold under back-pressure
        delay = int'(rand_word() % 32'd4);
        repeat (delay) begin
            @(negedge AXIS_ACLK);
            check_value("s_axi_bvalid", 32'd1, 32'(s_axi_bvalid));
        end
        @(posedge AXIS_ACLK);
        s_axi_bready <= 1'b1;
        @(posedge AXIS_ACLK);
        s_axi_bready <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int cnt;
        int delay;
        cnt = 0;
        @(posedge AXIS_ACLK);
        s_axi_araddr <= addr;
        s_axi_arvalid <= 1'b1;
        @(negedge AXIS_ACLK);
        while (!s_axi_arready) begin
            cnt++;
            if (cnt > WAIT_MAX) report_timeout("arready");
            @(negedge AXIS_ACLK);
        end
        @(posedge AXIS_ACLK);
        s_axi_arvalid <= 1'b0;
        cnt = 0;
        @(negedge AXIS_ACLK);
        while (!s_axi_rvalid) begin
            cnt++;
            if (cnt > WAIT_MAX) report_timeout("rvalid");
            @(negedge AXIS_ACLK);
        end
        data = s_axi_rdata;
        check_value("s_axi_rresp", 32'(hdc_reg_pkg::RESP_OKAY), 32'(s_axi_rresp));
        // rvalid and rdata held while rready stays low
        delay = int'(rand_word() % 32'd4);
        repeat (delay) begin
            @(negedge AXIS_ACLK);
            check_value("s_axi_rvalid", 32'd1, 32'(s_axi_rvalid));
            check_value("s_axi_rdata", data, s_axi_rdata);
        end
        @(posedge AXIS_ACLK);
        s_axi_rready <= 1'b1;
        @(posedge AXIS_ACLK);
        s_axi_rready <= 1'b0;
    endtask

    // ----------------------------------------
    // generation run and model check
    // ----------------------------------------
    task automatic run_generation(input logic [3:0] lim);
        logic [31:0] model;
        logic [31:0] value;
        logic [31:0] r;
        int          polls;
        int          item;
        int          word;
        // upper data bits are noise since only 4 bits are stored
        r = rand_word();
        bus_write(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), {r[31:4], lim},
                  pick_order());
        bus_write(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_CTRL), 32'd1, pick_order());
        polls = 0;
        value = 32'd1;
        while (value != 32'd0) begin
            polls++;
            if (polls > POLL_MAX) report_timeout("generate bit to clear");
            bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_CTRL), value);
            check_value("ctrl unused bits", 32'd0, value & ~32'd1);
        end
        bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), value);
        check_value("limit register", {28'd0, lim}, value);
        // model stream restarts at the seed for every run
        model = hdc_hv_pkg::PRNG_SEED;
        for (item = 0; item <= int'(lim); item++) begin
            for (word = 0; word < hdc_hv_pkg::HV_WORDS; word++) begin
                bus_read(item_addr(4'(item), 2'(word)), value);
                check_value($sformatf("item %0d word %0d", item, word), model, value);
                model = xorshift32(model);
            end
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] value;
        logic [31:0] r;
        logic [3:0]  lim;
        logic [3:0]  prev_lim;
        logic [1:0]  win;
        rand_state = 32'hb385;
        S_AXI_ARESETN <= 1'b0;
        s_axi_awaddr <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata <= '0;
        s_axi_wvalid <= 1'b0;
        s_axi_bready <= 1'b0;
        s_axi_araddr <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready <= 1'b0;
        repeat (8) @(posedge AXIS_ACLK);
        S_AXI_ARESETN <= 1'b1;

        // reset state
        @(negedge AXIS_ACLK);
        check_value("s_axi_awready", 32'd1, 32'(s_axi_awready));
        check_value("s_axi_wready", 32'd1, 32'(s_axi_wready));
        check_value("s_axi_arready", 32'd1, 32'(s_axi_arready));
        check_value("s_axi_bvalid", 32'd0, 32'(s_axi_bvalid));
        check_value("s_axi_rvalid", 32'd0, 32'(s_axi_rvalid));
        bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_CTRL), value);
        check_value("ctrl register", 32'd0, value);
        bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), value);
        check_value("limit register", 32'd0, value);

        // limit write and readback in random channel order
        repeat (10) begin
            r = rand_word();
            bus_write(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), r, pick_order());
            bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), value);
            check_value("limit register", {28'd0, r[3:0]}, value);
        end
        // unmapped indices 2 to 255
        repeat (4) begin
            r = rand_word();
            bus_read(reg_addr(hdc_reg_pkg::WIN_REG, 8'd2 + r[7:0] % 8'd254), value);
            check_value("unmapped register", 32'd0, value);
        end

        // two runs where the second limit is larger
        // so items past the first limit prove the counters restarted
        r = rand_word();
        lim = {1'b0, r[2:0]};
        run_generation(lim);
        prev_lim = lim;
        r = rand_word();
        lim = prev_lim + 4'd1 + {1'b0, r[2:0]};
        run_generation(lim);

        // windows 2 and 3 read zero and swallow writes
        repeat (6) begin
            r = rand_word();
            win = 2'd2 + {1'b0, r[0]};
            bus_write(reg_addr(win, {7'd0, r[1]}), rand_word(), pick_order());
            bus_read(reg_addr(win, r[9:2]), value);
            check_value("window 2/3 read", 32'd0, value);
            bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_CTRL), value);
            check_value("ctrl register", 32'd0, value);
            bus_read(reg_addr(hdc_reg_pkg::WIN_REG, hdc_reg_pkg::REG_LIMIT), value);
            check_value("limit register", {28'd0, lim}, value);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verilog/axi_lite_regs.sv
`timescale 1ns/1ns

module axi_lite_regs (
    input  logic                                AXIS_ACLK,
    input  logic                                S_AXI_ARESETN,
    // write address and data
    input  logic [hdc_reg_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [hdc_hv_pkg::WORD_W-1:0]       s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic [1:0]                          s_axi_bresp,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    // read address and data
    input  logic [hdc_reg_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [hdc_hv_pkg::WORD_W-1:0]       s_axi_rdata,
    output logic [1:0]                          s_axi_rresp,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready,
    // generator and item memory side
    output logic                                gen,
    output logic [hdc_hv_pkg::ITEM_AW-1:0]      limit,
    input  logic                                item_done,
    output logic [hdc_hv_pkg::ITEM_AW-1:0]      rd_item,
    output logic [hdc_hv_pkg::WORD_IDX_W-1:0]   rd_word,
    input  logic [hdc_hv_pkg::WORD_W-1:0]       rd_data
);

    logic [hdc_reg_pkg::ST_W-1:0]   state;
    hdc_reg_pkg::axi_loc_u          wr_loc;
    hdc_reg_pkg::axi_loc_u          rd_loc;
    // only the low bits ever reach a register
    logic [hdc_hv_pkg::ITEM_AW-1:0] wr_data;
    logic [hdc_hv_pkg::WORD_W-1:0]  reg_rdata;
    logic                           wr_commit;
    logic                           st_idle;
    logic                           st_addr;
    logic                           st_data;
    logic                           st_both;
    logic                           st_rwait;
    logic                           st_rvalid;
    logic                           aw_take;
    logic                           w_take;
    logic                           ar_take;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign st_idle = (state == hdc_reg_pkg::ST_IDLE);
    assign st_addr = (state == hdc_reg_pkg::ST_ADDR);
    assign st_data = (state == hdc_reg_pkg::ST_DATA);
    assign st_both = (state == hdc_reg_pkg::ST_BOTH);
    assign st_rwait = (state == hdc_reg_pkg::ST_RWAIT);
    assign st_rvalid = (state == hdc_reg_pkg::ST_RVALID);

    assign s_axi_awready = st_idle | st_data;
    assign s_axi_wready = st_idle | st_addr;
    // write request pending in idle wins over a read
    assign s_axi_arready = st_idle & ~s_axi_awvalid & ~s_axi_wvalid;
    assign s_axi_bvalid = st_both;
    assign s_axi_rvalid = st_rvalid;
    assign s_axi_bresp = hdc_reg_pkg::RESP_OKAY;
    assign s_axi_rresp = hdc_reg_pkg::RESP_OKAY;

    assign aw_take = s_axi_awvalid & s_axi_awready;
    assign w_take = s_axi_wvalid & s_axi_wready;
    assign ar_take = s_axi_arvalid & s_axi_arready;

    // ----------------------------------------
    // bus FSM
    // ----------------------------------------

    // commit flag is high only in the first bvalid cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= hdc_reg_pkg::ST_IDLE;
            wr_commit <= 1'b0;
        end else begin
            wr_commit <= 1'b0;
            case (state)
                hdc_reg_pkg::ST_IDLE: begin
                    if (aw_take && w_take) begin
                        state <= hdc_reg_pkg::ST_BOTH;
                        wr_commit <= 1'b1;
                    end else if (aw_take) begin
                        state <= hdc_reg_pkg::ST_ADDR;
                    end else if (w_take) begin
                        state <= hdc_reg_pkg::ST_DATA;
                    end else if (ar_take) begin
                        state <= hdc_reg_pkg::ST_RWAIT;
                    end
                end
                // address in and data still to come
                hdc_reg_pkg::ST_ADDR: begin
                    if (w_take) begin
                        state <= hdc_reg_pkg::ST_BOTH;
                        wr_commit <= 1'b1;
                    end
                end
                // data in and address still to come
                hdc_reg_pkg::ST_DATA: begin
                    if (aw_take) begin
                        state <= hdc_reg_pkg::ST_BOTH;
                        wr_commit <= 1'b1;
                    end
                end
                hdc_reg_pkg::ST_BOTH: begin
                    if (s_axi_bready) begin
                        state <= hdc_reg_pkg::ST_IDLE;
                    end
                end
                // memory word settles here
                hdc_reg_pkg::ST_RWAIT: begin
                    state <= hdc_reg_pkg::ST_RVALID;
                end
                hdc_reg_pkg::ST_RVALID: begin
                    if (s_axi_rready) begin
                        state <= hdc_reg_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= hdc_reg_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (aw_take) begin
            wr_loc <= s_axi_awaddr[hdc_reg_pkg::LOC_W-1:0];
        end
        if (w_take) begin
            wr_data <= s_axi_wdata[hdc_hv_pkg::ITEM_AW-1:0];
        end
        if (ar_take) begin
            rd_loc <= s_axi_araddr[hdc_reg_pkg::LOC_W-1:0];
        end
    end

    // ----------------------------------------
    // control registers
    // ----------------------------------------

    // a bus write on the done edge keeps generate as written
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            gen <= 1'b0;
            limit <= '0;
        end else if (wr_commit && wr_loc.regs.win == hdc_reg_pkg::WIN_REG) begin
            case (wr_loc.regs.idx)
                hdc_reg_pkg::REG_CTRL: gen <= wr_data[0];
                hdc_reg_pkg::REG_LIMIT: limit <= wr_data;
                default: ;
            endcase
        end else if (item_done) begin
            gen <= 1'b0;
        end
    end

    // ----------------------------------------
    // read path
    // ----------------------------------------

    // register value sampled in read-wait and held through read-valid
    always_ff @(posedge AXIS_ACLK) begin
        if (st_rwait) begin
            reg_rdata <= '0;
            if (rd_loc.regs.win == hdc_reg_pkg::WIN_REG) begin
                case (rd_loc.regs.idx)
                    hdc_reg_pkg::REG_CTRL:
                        reg_rdata <= {{(hdc_hv_pkg::WORD_W-1){1'b0}}, gen};
                    hdc_reg_pkg::REG_LIMIT:
                        reg_rdata <= {{(hdc_hv_pkg::WORD_W-hdc_hv_pkg::ITEM_AW){1'b0}}, limit};
                    default: ;
                endcase
            end
        end
    end

    // item window address goes straight to the memory
    assign rd_item = rd_loc.mem.item;
    assign rd_word = rd_loc.mem.word;

    // memory word in the item window else register value or zero
    assign s_axi_rdata = (rd_loc.mem.win == hdc_reg_pkg::WIN_ITEM) ? rd_data : reg_rdata;

endmodule

//--- verilog/hdc_hv_pkg.sv
package hdc_hv_pkg;

    // ----------------------------------------
    // word and hypervector geometry
    // ----------------------------------------

    // one prng word, also one bus word
    localparam int WORD_W = 32;
    // words per hypervector
    localparam int HV_WORDS = 4;
    localparam int WORD_IDX_W = 2;
    // hypervector width in bits
    localparam int HV_DIM = WORD_W * HV_WORDS;

    // index of the word that completes a vector
    localparam logic [WORD_IDX_W-1:0] LAST_WORD = WORD_IDX_W'(HV_WORDS - 1);

    // ----------------------------------------
    // item memory
    // ----------------------------------------
    localparam int ITEM_DEPTH = 16;
    localparam int ITEM_AW = 4;

    // xorshift start value, reloaded while generate is low
    localparam logic [WORD_W-1:0] PRNG_SEED = 32'd2463534242;

endpackage

//--- verilog/hdc_item_top.sv
`timescale 1ns/1ns

module hdc_item_top (
    input  logic                                AXIS_ACLK,
    input  logic                                S_AXI_ARESETN,
    input  logic [hdc_reg_pkg::AXI_ADDR_W-1:0]  s_axi_awaddr,
    input  logic                                s_axi_awvalid,
    output logic                                s_axi_awready,
    input  logic [hdc_hv_pkg::WORD_W-1:0]       s_axi_wdata,
    input  logic                                s_axi_wvalid,
    output logic                                s_axi_wready,
    output logic [1:0]                          s_axi_bresp,
    output logic                                s_axi_bvalid,
    input  logic                                s_axi_bready,
    input  logic [hdc_reg_pkg::AXI_ADDR_W-1:0]  s_axi_araddr,
    input  logic                                s_axi_arvalid,
    output logic                                s_axi_arready,
    output logic [hdc_hv_pkg::WORD_W-1:0]       s_axi_rdata,
    output logic [1:0]                          s_axi_rresp,
    output logic                                s_axi_rvalid,
    input  logic                                s_axi_rready
);

    // ----------------------------------------
    // control and memory nets
    // ----------------------------------------
    logic                                gen;
    logic [hdc_hv_pkg::ITEM_AW-1:0]      limit;
    logic                                item_done;
    logic                                wr_en;
    logic [hdc_hv_pkg::ITEM_AW-1:0]      wr_item;
    logic [hdc_hv_pkg::HV_DIM-1:0]       wr_vec;
    logic [hdc_hv_pkg::ITEM_AW-1:0]      rd_item;
    logic [hdc_hv_pkg::WORD_IDX_W-1:0]   rd_word;
    logic [hdc_hv_pkg::WORD_W-1:0]       rd_data;

    // bus side, owns generate and limit
    axi_lite_regs axi_lite_regs_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .gen           (gen),
        .limit         (limit),
        .item_done     (item_done),
        .rd_item       (rd_item),
        .rd_word       (rd_word),
        .rd_data       (rd_data)
    );

    // random vectors, one item every HV_WORDS cycles
    item_generator item_generator_inst (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .gen           (gen),
        .limit         (limit),
        .wr_en         (wr_en),
        .wr_item       (wr_item),
        .wr_vec        (wr_vec),
        .item_done     (item_done)
    );

    item_memory item_memory_inst (
        .AXIS_ACLK (AXIS_ACLK),
        .wr_en     (wr_en),
        .wr_item   (wr_item),
        .wr_vec    (wr_vec),
        .rd_item   (rd_item),
        .rd_word   (rd_word),
        .rd_data   (rd_data)
    );

endmodule

//--- verilog/hdc_reg_pkg.sv
package hdc_reg_pkg;

    // ----------------------------------------
    // bus widths and responses
    // ----------------------------------------
    localparam int AXI_ADDR_W = 32;
    // decoded part of the address, bits 11:0
    localparam int LOC_W = 12;
    localparam int REG_IDX_W = 8;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // address windows, bits 11:10
    localparam logic [1:0] WIN_REG = 2'd0;
    localparam logic [1:0] WIN_ITEM = 2'd1;

    // register indices inside the register window
    // bit 0 of ctrl is generate
    localparam logic [REG_IDX_W-1:0] REG_CTRL = 8'd0;
    // highest item index to generate
    localparam logic [REG_IDX_W-1:0] REG_LIMIT = 8'd1;

    // ----------------------------------------
    // bus FSM encodings
    // ----------------------------------------
    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IDLE = 3'd0;
    localparam logic [ST_W-1:0] ST_ADDR = 3'd1;
    localparam logic [ST_W-1:0] ST_DATA = 3'd2;
    localparam logic [ST_W-1:0] ST_BOTH = 3'd3;
    localparam logic [ST_W-1:0] ST_RWAIT = 3'd4;
    localparam logic [ST_W-1:0] ST_RVALID = 3'd5;

    // ----------------------------------------
    // address views
    // ----------------------------------------

    // register window view
    typedef struct packed {
        logic [1:0]           win;
        logic [REG_IDX_W-1:0] idx;
        logic [1:0]           byte_off;
    } axi_reg_loc_t;

    // item memory window view
    typedef struct packed {
        logic [1:0]                                          win;
        logic [REG_IDX_W-hdc_hv_pkg::ITEM_AW-hdc_hv_pkg::WORD_IDX_W-1:0] pad;
        logic [hdc_hv_pkg::ITEM_AW-1:0]                      item;
        logic [hdc_hv_pkg::WORD_IDX_W-1:0]                   word;
        logic [1:0]                                          byte_off;
    } axi_mem_loc_t;

    typedef union packed {
        axi_reg_loc_t regs;
        axi_mem_loc_t mem;
    } axi_loc_u;

endpackage

//--- verilog/item_generator.sv
`timescale 1ns/1ns

module item_generator (
    input  logic                            AXIS_ACLK,
    input  logic                            S_AXI_ARESETN,
    input  logic                            gen,
    input  logic [hdc_hv_pkg::ITEM_AW-1:0]  limit,
    output logic                            wr_en,
    output logic [hdc_hv_pkg::ITEM_AW-1:0]  wr_item,
    output logic [hdc_hv_pkg::HV_DIM-1:0]   wr_vec,
    output logic                            item_done
);

    // ----------------------------------------
    // xorshift source
    // ----------------------------------------

    // current state is the word handed out this cycle
    logic [hdc_hv_pkg::WORD_W-1:0] prng;
    logic [hdc_hv_pkg::WORD_W-1:0] prng_s1;
    logic [hdc_hv_pkg::WORD_W-1:0] prng_s2;
    logic [hdc_hv_pkg::WORD_W-1:0] prng_next;

    // shifts 13, 17, 5
    assign prng_s1 = prng ^ (prng << 13);
    assign prng_s2 = prng_s1 ^ (prng_s1 >> 17);
    assign prng_next = prng_s2 ^ (prng_s2 << 5);

    // seed reloads whenever generate is low
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            prng <= hdc_hv_pkg::PRNG_SEED;
        end else begin
            prng <= prng_next;
        end
    end

    // ----------------------------------------
    // word counter and assembly
    // ----------------------------------------
    logic [hdc_hv_pkg::WORD_IDX_W-1:0] word_cnt;
    logic [hdc_hv_pkg::HV_DIM-1:0]     asm_vec;
    logic [hdc_hv_pkg::ITEM_AW-1:0]    item_idx;
    logic                              last_word;

    assign last_word = (word_cnt == hdc_hv_pkg::LAST_WORD);

    // wraps after the last word of a vector
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            word_cnt <= '0;
        end else begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // word lands in its own slice
    always_ff @(posedge AXIS_ACLK) begin
        if (gen) begin
            asm_vec[word_cnt*hdc_hv_pkg::WORD_W +: hdc_hv_pkg::WORD_W] <= prng;
        end
    end

    // ----------------------------------------
    // item sequencing
    // ----------------------------------------

    // strobe follows the edge that stores the last word
    // done marks the vector for item limit
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            wr_en <= 1'b0;
            item_done <= 1'b0;
        end else begin
            wr_en <= last_word;
            item_done <= last_word && (item_idx == limit);
        end
    end

    // next item once the memory has taken the vector
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !gen) begin
            item_idx <= '0;
        end else if (wr_en) begin
            item_idx <= item_idx + 1'b1;
        end
    end

    assign wr_item = item_idx;
    assign wr_vec = asm_vec;

endmodule

//--- verilog/item_memory.sv
`timescale 1ns/1ns

module item_memory (
    input  logic                               AXIS_ACLK,
    input  logic                               wr_en,
    input  logic [hdc_hv_pkg::ITEM_AW-1:0]     wr_item,
    input  logic [hdc_hv_pkg::HV_DIM-1:0]      wr_vec,
    input  logic [hdc_hv_pkg::ITEM_AW-1:0]     rd_item,
    input  logic [hdc_hv_pkg::WORD_IDX_W-1:0]  rd_word,
    output logic [hdc_hv_pkg::WORD_W-1:0]      rd_data
);

    // ----------------------------------------
    // storage
    // ----------------------------------------

    // one full hypervector per entry
    logic [hdc_hv_pkg::HV_DIM-1:0] mem [hdc_hv_pkg::ITEM_DEPTH];

    // whole vector written at once
    always_ff @(posedge AXIS_ACLK) begin
        if (wr_en) begin
            mem[wr_item] <= wr_vec;
        end
    end

    // ----------------------------------------
    // word read
    // ----------------------------------------

    // registered, one cycle behind the address
    always_ff @(posedge AXIS_ACLK) begin
        rd_data <= mem[rd_item][rd_word*hdc_hv_pkg::WORD_W +: hdc_hv_pkg::WORD_W];
    end

endmodule
